//--- hw/smc_ahb_pkg.sv
package smc_ahb_pkg;

  //--------------------------------------------------------------------
  // AHB-Lite bus types seen by the memory controller
  //--------------------------------------------------------------------

  localparam int AHB_DATA_W = 32;        // Read and write data width

  // Transfer type
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,                  // No transfer
    TRN_BUSY   = 2'b01,                  // Master inserted idle beat
    TRN_NONSEQ = 2'b10,                  // First beat
    TRN_SEQ    = 2'b11                   // Following beats
  } htrans_e;

  // Transfer size, only the three SRAM-relevant codes
  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,                    // 8 bit
    SZ_HALF = 3'b001,                    // 16 bit
    SZ_WORD = 3'b010                     // 32 bit
  } hsize_e;

  // Slave response, two bits wide as on the bus
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01
  } hresp_e;

endpackage

//--- hw/smc_mem_pkg.sv
package smc_mem_pkg;

  //--------------------------------------------------------------------
  // External memory side definitions
  //--------------------------------------------------------------------

  localparam int EXT_ADDR_W  = 12;       // 4 KB byte-wide SRAM
  localparam int WAIT_STATES = 2;        // Strobe cycles per byte
  localparam int WAIT_CNT_W  = $clog2(WAIT_STATES + 1);  // Wait counter width

  // Access descriptor from AHB interface to MAC
  typedef struct packed {
    logic [31:0] addr;                   // Full AHB address
    logic [1:0]  size;                   // hsize[1:0]
    logic        write;                  // 1 = write
  } smc_req_t;

  // Single byte access handed to the state machine
  typedef struct packed {
    logic [EXT_ADDR_W-1:0] addr;         // Byte address in SRAM
    logic [7:0]            wdata;        // Byte taken from its lane
    logic                  write;
  } byte_acc_t;

  // External SRAM bus, all strobes active low
  typedef struct packed {
    logic [EXT_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
    logic                  n_cs;         // Chip select
    logic                  n_oe;         // Output enable
    logic                  n_we;         // Write enable
  } ext_bus_t;

endpackage

//--- hw/smc_ahb_lite_if.sv
module smc_ahb_lite_if
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;
(
  input  logic                  hclk5,
  input  logic                  n_sys_reset5,
  input  logic                  hsel,         // Slave select
  input  logic [31:0]           haddr,
  input  htrans_e               htrans,
  input  logic                  hwrite,
  input  hsize_e                hsize,
  input  logic [AHB_DATA_W-1:0] hwdata,
  input  logic                  hready,       // Muxed ready from the bus
  input  logic                  smc_done,     // Byte access in hold
  input  logic                  mac_done,     // Last byte of transfer
  input  logic [AHB_DATA_W-1:0] read_data,    // Lane-packed data from MAC
  output logic [AHB_DATA_W-1:0] smc_hrdata,
  output logic                  smc_hready,
  output hresp_e                smc_hresp,
  output logic                  new_access,   // Start strobe to MAC
  output smc_req_t              req,
  output logic [AHB_DATA_W-1:0] write_data
);

  logic active_trn;                           // NONSEQ or SEQ
  logic mis_err;                              // Misaligned address phase
  logic err_start;                            // Misalignment accepted on the bus
  logic r_ready;                              // Registered ready
  logic r_hresp;                              // Second error cycle pending

  //--------------------------------------------------------------------
  // Address phase decode
  //--------------------------------------------------------------------

  assign active_trn = (htrans == TRN_NONSEQ) || (htrans == TRN_SEQ);

  // Half on odd byte or word off a word boundary
  always_comb
  begin
    mis_err = 1'b0;
    if (active_trn && hsel)
    begin
      if ((hsize == SZ_HALF) && haddr[0])
        mis_err = 1'b1;
      if ((hsize == SZ_WORD) && (haddr[1:0] != 2'b00))
        mis_err = 1'b1;
    end
  end

  assign new_access = active_trn && hsel && hready && !mis_err;
  assign err_start  = mis_err && hready;    // Only a sampled phase counts

  // Descriptor straight from the address phase
  always_comb
  begin
    req.addr  = haddr;
    req.size  = hsize[1:0];
    req.write = hwrite;
  end

  //--------------------------------------------------------------------
  // Response, two cycle ERROR
  //--------------------------------------------------------------------

  always_ff @(posedge hclk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      smc_hresp <= RSP_OKAY;
      r_hresp   <= 1'b0;
    end
    else if (err_start)
    begin
      smc_hresp <= RSP_ERROR;                 // First cycle, ready low
      r_hresp   <= 1'b1;
    end
    else if (r_hresp)
    begin
      smc_hresp <= RSP_ERROR;                 // Second cycle, ready high
      r_hresp   <= 1'b0;
    end
    else
    begin
      smc_hresp <= RSP_OKAY;
    end
  end

  //--------------------------------------------------------------------
  // Ready generation
  //--------------------------------------------------------------------

  // Low through a data phase, zero wait for idle or unselected
  always_ff @(posedge hclk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
      r_ready <= 1'b1;
    else if (r_hresp)
      r_ready <= 1'b1;                        // Closes the error response
    else if (hready)
      r_ready <= !(new_access || err_start);
  end

  assign smc_hready = r_ready || (smc_done && mac_done);

  // Data paths pass straight through
  assign smc_hrdata = read_data;
  assign write_data = hwdata;

endmodule

//--- hw/smc_mac.sv
module smc_mac
  import smc_mem_pkg::*;
(
  input  logic        hclk5,
  input  logic        n_sys_reset5,
  input  logic        new_access,    // Valid AHB access this cycle
  input  smc_req_t    req,
  input  logic [31:0] write_data,    // hwdata, stable in data phase
  input  logic        smc_done,      // Byte in hold
  input  logic [7:0]  rd_byte,       // Byte read by the state machine
  output logic        byte_start,    // One cycle start per byte
  output byte_acc_t   byte_acc,
  output logic        mac_done,      // Final byte in progress
  output logic [31:0] read_data
);

  smc_req_t    req_q;                // Latched request
  logic        busy;
  logic [1:0]  byte_cnt;             // Byte number within transfer
  logic [1:0]  last_cnt;             // Index of final byte
  logic [1:0]  lane;                 // AHB byte lane of current byte
  logic        take_req;
  logic [31:0] rd_q;                 // Bytes read so far

  // Number of bytes from size
  always_comb
  begin
    case (req_q.size)
      2'd0:    last_cnt = 2'd0;      // Byte
      2'd1:    last_cnt = 2'd1;      // Half
      default: last_cnt = 2'd3;      // Word
    endcase
  end

  assign lane     = req_q.addr[1:0] + byte_cnt;     // Wraps within the word
  assign mac_done = busy && (byte_cnt == last_cnt);

  // New request when idle or as the previous one completes
  assign take_req = new_access && (!busy || (smc_done && mac_done));

  //--------------------------------------------------------------------
  // Byte sequencer
  //--------------------------------------------------------------------

  always_ff @(posedge hclk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      busy       <= 1'b0;
      byte_cnt   <= 2'd0;
      byte_start <= 1'b0;
    end
    else
    begin
      byte_start <= 1'b0;                    // Strobe by default
      if (take_req)
      begin
        busy       <= 1'b1;
        byte_cnt   <= 2'd0;
        byte_start <= 1'b1;                  // First byte next cycle
      end
      else if (busy && smc_done)
      begin
        if (mac_done)
          busy <= 1'b0;                      // Transfer complete
        else
        begin
          byte_cnt   <= byte_cnt + 2'd1;
          byte_start <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge hclk5)
  begin
    if (take_req)
      req_q <= req;
  end

  // Byte access, write byte picked from its lane
  always_comb
  begin
    byte_acc.addr  = req_q.addr[EXT_ADDR_W-1:0] + EXT_ADDR_W'(byte_cnt);
    byte_acc.wdata = write_data[{lane, 3'b000} +: 8];
    byte_acc.write = req_q.write;
  end

  //--------------------------------------------------------------------
  // Read assembly
  //--------------------------------------------------------------------

  always_ff @(posedge hclk5)
  begin
    if (busy && smc_done && !req_q.write)
      rd_q[{lane, 3'b000} +: 8] <= rd_byte;
  end

  // Final byte merged in during its hold cycle
  always_comb
  begin
    read_data = rd_q;
    if (smc_done && !req_q.write)
      read_data[{lane, 3'b000} +: 8] = rd_byte;
  end

endmodule

//--- hw/smc_state.sv
module smc_state
  import smc_mem_pkg::*;
(
  input  logic       hclk5,
  input  logic       n_sys_reset5,
  input  logic       byte_start,     // Start of one byte access
  input  byte_acc_t  byte_acc,
  input  logic [7:0] ext_rdata,      // SRAM read data
  output logic       smc_done,       // High in hold
  output logic [7:0] rd_byte,
  output ext_bus_t   ext
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,                        // Address and select out
    ST_STROBE,                       // OE or WE low
    ST_HOLD                          // Strobe released, bus held
  } state_e;

  state_e                state;
  state_e                state_nxt;
  logic [WAIT_CNT_W-1:0] wait_cnt;   // Strobe cycles elapsed
  logic                  last_strobe;
  byte_acc_t             acc_q;      // Access held for the whole cycle
  logic                  n_cs_q;
  logic                  n_oe_q;
  logic                  n_we_q;

  assign last_strobe = (state == ST_STROBE) &&
                       (wait_cnt == WAIT_CNT_W'(WAIT_STATES - 1));

  //--------------------------------------------------------------------
  // External cycle FSM
  //--------------------------------------------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:   if (byte_start) state_nxt = ST_SETUP;
      ST_SETUP:  state_nxt = ST_STROBE;
      ST_STROBE: if (last_strobe) state_nxt = ST_HOLD;
      default:   state_nxt = ST_IDLE;       // Hold lasts one cycle
    endcase
  end

  always_ff @(posedge hclk5 or negedge n_sys_reset5)
  begin
    if (!n_sys_reset5)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      n_cs_q   <= 1'b1;
      n_oe_q   <= 1'b1;
      n_we_q   <= 1'b1;
    end
    else
    begin
      state <= state_nxt;
      if (state == ST_STROBE)
        wait_cnt <= wait_cnt + 1'b1;
      else
        wait_cnt <= '0;
      // Strobes registered from next state, glitch free
      n_cs_q <= (state_nxt == ST_IDLE);
      n_oe_q <= !((state_nxt == ST_STROBE) && !acc_q.write);
      n_we_q <= !((state_nxt == ST_STROBE) && acc_q.write);
    end
  end

  // Access latch and read capture
  always_ff @(posedge hclk5)
  begin
    if (byte_start && (state == ST_IDLE))
      acc_q <= byte_acc;
    if (last_strobe && !acc_q.write)
      rd_byte <= ext_rdata;              // End of strobe phase
  end

  assign smc_done = (state == ST_HOLD);

  always_comb
  begin
    ext.addr  = acc_q.addr;
    ext.wdata = acc_q.wdata;
    ext.n_cs  = n_cs_q;
    ext.n_oe  = n_oe_q;
    ext.n_we  = n_we_q;
  end

endmodule

//--- hw/smc_lite.sv
module smc_lite
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;
(
  input  logic                  hclk5,
  input  logic                  n_sys_reset5,
  input  logic                  hsel,
  input  logic [31:0]           haddr,
  input  htrans_e               htrans,
  input  logic                  hwrite,
  input  hsize_e                hsize,
  input  logic [AHB_DATA_W-1:0] hwdata,
  input  logic                  hready,
  input  logic [7:0]            ext_rdata,
  output logic [AHB_DATA_W-1:0] smc_hrdata,
  output logic                  smc_hready,
  output hresp_e                smc_hresp,
  output ext_bus_t              ext
);

  logic                  new_access;
  smc_req_t              req;
  logic [AHB_DATA_W-1:0] write_data;
  logic [AHB_DATA_W-1:0] read_data;
  logic                  mac_done;
  logic                  smc_done;
  logic                  byte_start;
  byte_acc_t             byte_acc;
  logic [7:0]            rd_byte;

  // AHB slave side
  smc_ahb_lite_if u_ahb_if (.hclk5, .n_sys_reset5, .hsel, .haddr, .htrans, .hwrite,
                            .hsize, .hwdata, .hready, .smc_done, .mac_done, .read_data,
                            .smc_hrdata, .smc_hready, .smc_hresp, .new_access, .req,
                            .write_data);

  // Transfer to byte splitter
  smc_mac u_mac (.hclk5, .n_sys_reset5, .new_access, .req, .write_data, .smc_done,
                 .rd_byte, .byte_start, .byte_acc, .mac_done, .read_data);

  // External bus timing
  smc_state u_state (.hclk5, .n_sys_reset5, .byte_start, .byte_acc, .ext_rdata,
                     .smc_done, .rd_byte, .ext);

endmodule

//--- testbench/ext_sram_model.sv
module ext_sram_model
  import smc_mem_pkg::*;
(
  input  ext_bus_t   ext,            // Bus from the controller
  output logic [7:0] rdata           // Asynchronous read data
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] mem [0:(1 << EXT_ADDR_W)-1];
  logic       n_we;

  assign n_we = ext.n_we;

  // Power-up contents, every address bit takes part
  initial
  begin
    for (int i = 0; i < (1 << EXT_ADDR_W); i++)
      mem[i] = 8'(i) ^ 8'(i >> 4) ^ 8'h5a;
  end

  // Write completes on the rising edge of n_we
  always @(posedge n_we)
  begin
    if (!ext.n_cs)
      mem[ext.addr] <= ext.wdata;
  end

  assign rdata = mem[ext.addr];      // No output enable gating

endmodule

//--- testbench/tb_smc_lite.sv
module tb_smc_lite
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BYTE_CYCLES = WAIT_STATES + 3;  // Start, setup, strobes and hold
  localparam int XFER_LIMIT  = 4 * BYTE_CYCLES;  // Word data phase waits one less
  localparam int TIMEOUT     = 8000; // About 300 transfers of up to 26 cycles, plus reset

  // One finished transfer, expected and observed side by side
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] exp_data;
    logic [31:0] mask;               // Lanes that carry read data
    logic [31:0] got_data;
    logic        exp_err;
    logic        got_err_low;        // ERROR seen while hready low
    hresp_e      got_resp;
    logic [4:0]  exp_wait;
    logic [4:0]  got_wait;
    logic        quiet;              // No external access expected
    logic        strobe_seen;
  } xfer_rec_t;

  logic        hclk5;
  logic        n_sys_reset5;
  logic        hsel;
  logic [31:0] haddr;
  htrans_e     htrans;
  logic        hwrite;
  hsize_e      hsize;
  logic [31:0] hwdata;
  logic [7:0]  ext_rdata;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  hresp_e      smc_hresp;
  ext_bus_t    ext;

  logic [7:0]  shadow [0:4095];      // Expected SRAM contents
  xfer_rec_t   rec_q[$];             // Finished transfers awaiting compare
  logic [11:0] waddr_q[$];           // Expected address of each write byte
  xfer_rec_t   chk_rec;
  logic [11:0] exp_waddr;
  logic        prev_we = 1'b1;
  int          errors;
  int          test_err_base;
  int          n_pass;
  int          n_fail;
  int          we_bytes;
  int          we_base;
  int          cycle_cnt;
  int          seed;
  logic [31:0] rnd;
  logic [31:0] rnd_data;
  logic [31:0] rnd_addr;
  hsize_e      rnd_size;

  smc_lite dut (.hclk5, .n_sys_reset5, .hsel, .haddr, .htrans, .hwrite, .hsize, .hwdata,
                .hready(smc_hready), .ext_rdata, .smc_hrdata, .smc_hready, .smc_hresp,
                .ext);            // Single slave, ready fed straight back

  ext_sram_model u_sram (.ext, .rdata(ext_rdata));

  initial
  begin
    hclk5 = 1'b0;
    forever #10 hclk5 = ~hclk5;      // 50 MHz
  end

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 4) ^ 8'h5a;
  endfunction

  // Shadow bytes placed in the lanes given by the address
  function automatic logic [31:0] ref_read(input logic [11:0] addr, input int nbytes);
    logic [31:0] data;
    logic [1:0]  lane;
    data = '0;
    for (int i = 0; i < nbytes; i++)
    begin
      lane = addr[1:0] + 2'(i);
      data[8*lane +: 8] = shadow[addr + 12'(i)];
    end
    return data;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [1:0] low, input int nbytes);
    logic [31:0] mask;
    logic [1:0]  lane;
    mask = '0;
    for (int i = 0; i < nbytes; i++)
    begin
      lane = low + 2'(i);
      mask[8*lane +: 8] = 8'hff;
    end
    return mask;
  endfunction

  //--------------------------------------------------------------------
  // AHB master
  //--------------------------------------------------------------------

  // Entered on a falling edge with the bus ready; returns with the bus ready again
  task automatic xfer(input logic sel, input htrans_e trn, input logic wr, input hsize_e sz,
                      input logic [31:0] addr, input logic [31:0] wdata);
    xfer_rec_t  rec;
    logic       active;
    logic       mis;
    int         nbytes;
    int         cycles;
    logic [1:0] lane;
    nbytes = 1 << int'(sz);
    active = sel && ((trn == TRN_NONSEQ) || (trn == TRN_SEQ));
    mis    = active && (((sz == SZ_HALF) && addr[0]) ||
                        ((sz == SZ_WORD) && (addr[1:0] != 2'b00)));
    rec          = '0;
    rec.addr     = addr;
    rec.exp_err  = mis;
    rec.quiet    = !active || mis;
    // Ready returns in the hold cycle of the last byte
    rec.exp_wait = mis ? 5'd1 : (rec.quiet ? 5'd0 : 5'(BYTE_CYCLES * nbytes - 1));
    if (!rec.quiet && !wr)
    begin
      rec.exp_data = ref_read(addr[11:0], nbytes);
      rec.mask     = lane_mask(addr[1:0], nbytes);
    end
    if (!rec.quiet && wr)
    begin
      for (int i = 0; i < nbytes; i++)
      begin
        lane = addr[1:0] + 2'(i);
        shadow[addr[11:0] + 12'(i)] = wdata[8*lane +: 8];   // Byte from its lane
        waddr_q.push_back(addr[11:0] + 12'(i));
      end
    end
    hsel   = sel;                    // Address phase
    haddr  = addr;
    htrans = trn;
    hwrite = wr;
    hsize  = sz;
    @(negedge hclk5);
    hsel   = 1'b0;                   // Data phase
    htrans = TRN_IDLE;
    hwdata = wdata;
    cycles = 0;
    while (!smc_hready && (cycles < XFER_LIMIT))
    begin
      if (smc_hresp == RSP_ERROR)
        rec.got_err_low = 1'b1;
      if (!ext.n_oe || !ext.n_we)
        rec.strobe_seen = 1'b1;
      @(negedge hclk5);
      cycles++;
    end
    if (!smc_hready)
    begin
      $display("transfer at %h never got hready within %0d cycles", addr, XFER_LIMIT);
      errors++;
    end
    rec.got_data = smc_hrdata;       // Stable up to the completing edge
    rec.got_resp = smc_hresp;
    rec.got_wait = 5'(cycles);
    if (rec.quiet)
    begin
      // Bus left idle for one byte time, any strobe is a stray access
      for (int i = 0; i < BYTE_CYCLES; i++)
      begin
        @(negedge hclk5);
        if (!ext.n_oe || !ext.n_we)
          rec.strobe_seen = 1'b1;
      end
    end
    rec_q.push_back(rec);
  endtask

  task automatic finish_test(input string name);
    @(posedge hclk5);
    @(negedge hclk5);                // Checker has drained the queue
    if (errors == test_err_base)
    begin
      n_pass++;
      $display("test %s: ok", name);
    end
    else
    begin
      n_fail++;
      $display("test %s: %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  //--------------------------------------------------------------------
  // Checkers
  //--------------------------------------------------------------------

  always @(posedge hclk5)
  begin
    while (rec_q.size() > 0)
    begin
      chk_rec = rec_q.pop_front();
      if ((chk_rec.got_data & chk_rec.mask) != (chk_rec.exp_data & chk_rec.mask))
      begin
        $display("error smc_hrdata at %h: got %h exp %h", chk_rec.addr,
                 chk_rec.got_data & chk_rec.mask, chk_rec.exp_data & chk_rec.mask);
        errors++;
      end
      if (chk_rec.got_resp != (chk_rec.exp_err ? RSP_ERROR : RSP_OKAY))
      begin
        $display("error smc_hresp at %h: got %h exp %h", chk_rec.addr, chk_rec.got_resp,
                 chk_rec.exp_err ? RSP_ERROR : RSP_OKAY);
        errors++;
      end
      if (chk_rec.exp_err && !chk_rec.got_err_low)
      begin
        $display("ERROR at %h came without its first cycle with hready low", chk_rec.addr);
        errors++;
      end
      if (chk_rec.got_wait != chk_rec.exp_wait)
      begin
        $display("error smc_hready wait cycles at %h: got %h exp %h", chk_rec.addr,
                 chk_rec.got_wait, chk_rec.exp_wait);
        errors++;
      end
      if (chk_rec.quiet && chk_rec.strobe_seen)
      begin
        $display("external strobe went low for transfer at %h with no access", chk_rec.addr);
        errors++;
      end
    end
  end

  // External bus protocol and write addresses
  always @(negedge hclk5)
  begin
    if (!ext.n_we && ext.n_cs)
    begin
      $display("n_we went low while n_cs was high");
      errors++;
    end
    if (!ext.n_we && prev_we)        // Start of a write strobe
    begin
      we_bytes++;
      if (waddr_q.size() == 0)
      begin
        $display("n_we went low with no write byte outstanding");
        errors++;
      end
      else
      begin
        exp_waddr = waddr_q.pop_front();
        if (ext.addr != exp_waddr)
        begin
          $display("error ext.addr: got %h exp %h", ext.addr, exp_waddr);
          errors++;
        end
      end
    end
    prev_we = ext.n_we;
  end

  // Run limit
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT)
    begin
      @(posedge hclk5);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing", TIMEOUT);
    $display("Test failed");
    $finish;
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial
  begin
    seed          = 99;
    errors        = 0;
    test_err_base = 0;
    n_pass        = 0;
    n_fail        = 0;
    we_bytes      = 0;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = TRN_IDLE;
    hwrite        = 1'b0;
    hsize         = SZ_BYTE;
    hwdata        = '0;
    n_sys_reset5  = 1'b0;
    for (int a = 0; a < 4096; a++)
      shadow[a] = fill_byte(a);
    repeat (8) @(negedge hclk5);
    n_sys_reset5 = 1'b1;
    @(negedge hclk5);

    rnd_data = $random(seed);
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_WORD, 32'h100, rnd_data);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h100, 32'h0);
    finish_test("word write then read");

    // Every byte and half offset, then narrow reads
    for (int i = 0; i < 4; i++)
      xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_BYTE, 32'h200 + i, 32'h11223344 << i);
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_HALF, 32'h204, 32'hcafe_beef);
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_HALF, 32'h206, 32'h5a5a_0f0f);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h200, 32'h0);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h204, 32'h0);
    for (int i = 0; i < 4; i++)
      xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_BYTE, 32'h200 + i, 32'h0);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_HALF, 32'h204, 32'h0);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_HALF, 32'h206, 32'h0);
    finish_test("byte and half lanes");

    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_HALF, 32'h301, 32'hffff_ffff);
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_WORD, 32'h302, 32'hffff_ffff);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h303, 32'h0);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h300, 32'h0);  // Still power-up data
    finish_test("misaligned error");

    xfer(1'b1, TRN_IDLE, 1'b1, SZ_WORD, 32'h400, 32'hdead_0001);
    xfer(1'b1, TRN_BUSY, 1'b1, SZ_WORD, 32'h400, 32'hdead_0002);
    xfer(1'b0, TRN_NONSEQ, 1'b1, SZ_WORD, 32'h400, 32'hdead_0003);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h400, 32'h0);
    for (int i = 0; i < 4; i++)      // Each address phase overlaps the last ready
      xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_WORD, 32'h410 + 4 * i, $random(seed));
    for (int i = 0; i < 4; i++)
      xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h410 + 4 * i, 32'h0);
    finish_test("idle busy unselected and back to back");

    we_base = we_bytes;
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_WORD, 32'h500, 32'h0102_0304);
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_HALF, 32'h506, 32'habcd_0000);
    xfer(1'b1, TRN_NONSEQ, 1'b1, SZ_BYTE, 32'h509, 32'h0000_7700);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h504, 32'h0);
    xfer(1'b1, TRN_NONSEQ, 1'b0, SZ_WORD, 32'h508, 32'h0);
    if (we_bytes - we_base != 7)
    begin
      $display("error n_we strobes: got %h exp %h", we_bytes - we_base, 7);
      errors++;
    end
    if (waddr_q.size() != 0)
    begin
      $display("%0d write bytes never reached the SRAM", waddr_q.size());
      errors++;
    end
    finish_test("external write strobes");

    for (int n = 0; n < 250; n++)
    begin
      rnd      = $random(seed);
      rnd_data = $random(seed);
      case (rnd[1:0])
        2'd0:    rnd_size = SZ_BYTE;
        2'd1:    rnd_size = SZ_HALF;
        default: rnd_size = SZ_WORD;
      endcase
      rnd_addr = {20'h0, rnd[15:4]};
      if (rnd[16])
        rnd_addr[1:0] = 2'b00;       // Keep most sizes aligned
      xfer(1'b1, rnd[3] ? TRN_SEQ : TRN_NONSEQ, rnd[2], rnd_size, rnd_addr, rnd_data);
    end
    finish_test("random transfers");

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if ((n_fail == 0) && (errors == 0))
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- files.f
hw/smc_ahb_pkg.sv
hw/smc_mem_pkg.sv
hw/smc_ahb_lite_if.sv
hw/smc_mac.sv
hw/smc_state.sv
hw/smc_lite.sv
testbench/ext_sram_model.sv
testbench/tb_smc_lite.sv
